/* Makefile */
TOP := tb_video_gen
BIN := obj_dir/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qxF '>>> PASS'

$(BIN): sim.f $(shell grep -v '^+' sim.f) $(wildcard sim/*.svh)
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* rtl/bitmap_playfield.sv */
/*
 * 8 bpp bitmap playfield. Prefetches one vram word every two clocks, unpacks
 * the high byte first and applies colorbase and border; syncs are delayed to match.
 */
`default_nettype none
`timescale 1ns/100ps

module bitmap_playfield (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire video_timing_pkg::raster_t raster_i,
    input  wire video_cfg_pkg::vid_cfg_t   vid_cfg_i,
    input  wire video_cfg_pkg::pf_cfg_t    pf_cfg_i,
    input  wire logic                      hsync_i,
    input  wire logic                      vsync_i,
    input  wire logic                      dv_de_i,
    output logic                           vram_sel_o,
    output video_cfg_pkg::addr_t           vram_addr_o,
    input  wire video_cfg_pkg::word_t      vram_data_i,
    output video_cfg_pkg::color_t          color_index_o,
    output logic                           hsync_o,
    output logic                           vsync_o,
    output logic                           dv_de_o,
    output logic                           h_blank_o,
    output logic                           v_blank_o
);
    import video_timing_pkg::*;
    import video_cfg_pkg::*;

    localparam int FETCH_LEAD  = 8;                         // clocks ahead of column 0
    localparam int FETCH_START = TOTAL_WIDTH - FETCH_LEAD;
    localparam int FETCH_END   = VISIBLE_WIDTH - FETCH_LEAD;
    localparam int WORD_STAGES = 4;                         // two-word prefetch plus pipeline

    addr_t      line_addr;
    addr_t      fetch_addr;
    addr_t      first_addr;
    logic       next_line_vis;
    logic       word_phase;
    logic       fetch_first;
    logic       fetch_slot;
    logic       rd_valid;
    word_t      word_q [WORD_STAGES];
    color_t     pix1;
    logic       show1;
    logic [1:0] blank_d1;

    always_comb begin
        next_line_vis = (raster_i.v_count == vres_t'(TOTAL_HEIGHT - 1)) ||
                        (raster_i.v_count < vres_t'(VISIBLE_HEIGHT - 1));
        word_phase    = (raster_i.h_count % PIXELS_PER_WORD) == PIXELS_PER_WORD - 1;
        fetch_first   = raster_i.h_count == hres_t'(FETCH_START - 1);
        // row 0 begins at start_addr, later rows one line_len past the current row
        first_addr    = raster_i.v_visible ? line_addr + pf_cfg_i.line_len : pf_cfg_i.start_addr;
        fetch_slot    = word_phase && !pf_cfg_i.blank &&
                        ((raster_i.h_count >= hres_t'(FETCH_START - 1) && next_line_vis) ||
                         (raster_i.h_count < hres_t'(FETCH_END - 1) && raster_i.v_visible));
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o <= 1'b0;
            rd_valid   <= 1'b0;
            line_addr  <= '0;
            fetch_addr <= '0;
        end else begin
            vram_sel_o <= fetch_slot;
            rd_valid   <= vram_sel_o;                       // data returns one clock later
            if (raster_i.end_of_frame) begin
                line_addr <= pf_cfg_i.start_addr;
            end else if (raster_i.end_of_line && raster_i.v_visible) begin
                line_addr <= line_addr + pf_cfg_i.line_len;
            end
            if (fetch_slot) begin
                fetch_addr <= (fetch_first ? first_addr : fetch_addr) + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_slot) begin
            vram_addr_o <= fetch_first ? first_addr : fetch_addr;
        end
        if (word_phase) begin
            word_q[0] <= rd_valid ? vram_data_i : '0;
            for (int i = 1; i < WORD_STAGES; i++) begin
                word_q[i] <= word_q[i-1];
            end
        end
        // even column takes the high byte
        pix1  <= (word_phase ? word_q[WORD_STAGES-1][7:0] : word_q[WORD_STAGES-1][15:8]) ^
                 pf_cfg_i.colorbase;
        show1 <= !pf_cfg_i.blank && (raster_i.h_count >= vid_cfg_i.vid_left) &&
                 (raster_i.h_count < vid_cfg_i.vid_right);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_index_o <= '0;
            hsync_o       <= ~SYNC_POLARITY;
            vsync_o       <= ~SYNC_POLARITY;
            dv_de_o       <= 1'b0;
            blank_d1      <= '1;
            h_blank_o     <= 1'b1;
            v_blank_o     <= 1'b1;
        end else begin
            color_index_o <= show1 ? pix1 : vid_cfg_i.border_color;   // border not XORed
            hsync_o       <= hsync_i;                                 // timing regs are one stage in
            vsync_o       <= vsync_i;
            dv_de_o       <= dv_de_i;
            blank_d1      <= {~raster_i.h_visible, ~raster_i.v_visible};
            {h_blank_o, v_blank_o} <= blank_d1;
        end
    end

    // only the last raster line may fetch outside the visible rows (row 0 prefetch)
    assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> (raster_i.v_visible || raster_i.v_count == vres_t'(TOTAL_HEIGHT - 1)))
        else $error("vram read outside the fetch rows");

endmodule

`default_nettype wire

/* rtl/video_cfg_pkg.sv */
/*
 * Register map, reset values and configuration bundles of the video generator.
 * Shared by the register block, the playfield and the top level.
 */
`default_nettype none

package video_cfg_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;                // vram word address
    typedef logic [7:0]  color_t;               // palette index
    typedef logic [5:0]  reg_num_t;

    localparam int HPOS_W = 10;                 // width of vid_left / vid_right
    typedef logic [HPOS_W-1:0] hpos_t;

    // register numbers
    localparam reg_num_t REG_VID_CTRL     = 6'd0;    // border colour in [7:0]
    localparam reg_num_t REG_SCANLINE     = 6'd2;    // read only
    localparam reg_num_t REG_VID_LEFT     = 6'd3;
    localparam reg_num_t REG_VID_RIGHT    = 6'd4;
    localparam reg_num_t REG_PF_GFX_CTRL  = 6'd16;   // colorbase [15:8], blank [7]
    localparam reg_num_t REG_PF_DISP_ADDR = 6'd18;
    localparam reg_num_t REG_PF_LINE_LEN  = 6'd19;

    localparam int PIXELS_PER_WORD = 2;          // 8 bpp, high byte first

    // reset values
    localparam color_t BORDER_RESET    = 8'h08;
    localparam word_t  LINE_LEN_RESET  = word_t'(video_timing_pkg::VISIBLE_WIDTH / PIXELS_PER_WORD);
    localparam logic   PF_BLANK_RESET  = 1'b1;   // playfield comes up blanked
    localparam hpos_t  VID_RIGHT_RESET = hpos_t'(video_timing_pkg::VISIBLE_WIDTH);

    typedef struct packed {
        color_t border_color;
        hpos_t  vid_left;                        // first column showing the playfield
        hpos_t  vid_right;                       // first border column on the right
    } vid_cfg_t;

    typedef struct packed {
        logic   blank;
        color_t colorbase;                       // XORed into every pixel index
        addr_t  start_addr;
        word_t  line_len;                        // words added per display line
    } pf_cfg_t;

endpackage

`default_nettype wire

/* rtl/video_gen.sv */
/*
 * Top level of the video generator. Connects raster timing, the register
 * block and the bitmap playfield to the register port, vram and video pins.
 */
`default_nettype none
`timescale 1ns/100ps

module video_gen (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    reg_wr_i,
    input  wire video_cfg_pkg::reg_num_t reg_num_i,
    input  wire video_cfg_pkg::word_t    reg_data_i,
    output video_cfg_pkg::word_t         reg_data_o,
    output logic                         video_intr_o,
    output logic                         vram_sel_o,
    output video_cfg_pkg::addr_t         vram_addr_o,
    input  wire video_cfg_pkg::word_t    vram_data_i,
    output video_cfg_pkg::color_t        color_index_o,
    output logic                         hsync_o,
    output logic                         vsync_o,
    output logic                         dv_de_o,
    output logic                         h_blank_o,
    output logic                         v_blank_o
);
    import video_timing_pkg::*;
    import video_cfg_pkg::*;

    raster_t  raster;
    vid_cfg_t vid_cfg;
    pf_cfg_t  pf_cfg;
    logic     tm_hsync;                     // undelayed, one stage behind raster
    logic     tm_vsync;
    logic     tm_de;

    video_timing u_timing (
        .clk      (clk),
        .reset_i  (reset_i),
        .raster_o (raster),
        .hsync_o  (tm_hsync),
        .vsync_o  (tm_vsync),
        .dv_de_o  (tm_de)
    );

    video_regs u_regs (
        .clk          (clk),
        .reset_i      (reset_i),
        .reg_wr_i     (reg_wr_i),
        .reg_num_i    (reg_num_i),
        .reg_data_i   (reg_data_i),
        .reg_data_o   (reg_data_o),
        .raster_i     (raster),
        .vid_cfg_o    (vid_cfg),
        .pf_cfg_o     (pf_cfg),
        .video_intr_o (video_intr_o)
    );

    bitmap_playfield u_playfield (
        .clk           (clk),
        .reset_i       (reset_i),
        .raster_i      (raster),
        .vid_cfg_i     (vid_cfg),
        .pf_cfg_i      (pf_cfg),
        .hsync_i       (tm_hsync),
        .vsync_i       (tm_vsync),
        .dv_de_i       (tm_de),
        .vram_sel_o    (vram_sel_o),
        .vram_addr_o   (vram_addr_o),
        .vram_data_i   (vram_data_i),
        .color_index_o (color_index_o),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .dv_de_o       (dv_de_o),
        .h_blank_o     (h_blank_o),
        .v_blank_o     (v_blank_o)
    );

endmodule

`default_nettype wire

/* rtl/video_regs.sv */
/*
 * Video configuration registers. A write lands on the edge where reg_wr_i is
 * high; read data for reg_num_i follows one clock later. Also raises vblank irq.
 */
`default_nettype none
`timescale 1ns/100ps

module video_regs (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire logic                      reg_wr_i,
    input  wire video_cfg_pkg::reg_num_t   reg_num_i,
    input  wire video_cfg_pkg::word_t      reg_data_i,
    output video_cfg_pkg::word_t           reg_data_o,
    input  wire video_timing_pkg::raster_t raster_i,
    output video_cfg_pkg::vid_cfg_t        vid_cfg_o,
    output video_cfg_pkg::pf_cfg_t         pf_cfg_o,
    output logic                           video_intr_o
);
    import video_cfg_pkg::*;

    word_t rd_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vid_cfg_o.border_color <= BORDER_RESET;
            vid_cfg_o.vid_left     <= '0;
            vid_cfg_o.vid_right    <= VID_RIGHT_RESET;
            pf_cfg_o.blank         <= PF_BLANK_RESET;
            pf_cfg_o.colorbase     <= '0;
            pf_cfg_o.start_addr    <= '0;
            pf_cfg_o.line_len      <= LINE_LEN_RESET;
            video_intr_o           <= 1'b0;
        end else begin
            video_intr_o <= raster_i.end_of_visible;    // once per frame, after row 479
            if (reg_wr_i) begin
                case (reg_num_i)
                    REG_VID_CTRL:     vid_cfg_o.border_color <= reg_data_i[7:0];
                    REG_VID_LEFT:     vid_cfg_o.vid_left     <= hpos_t'(reg_data_i);
                    REG_VID_RIGHT:    vid_cfg_o.vid_right    <= hpos_t'(reg_data_i);
                    REG_PF_GFX_CTRL: begin
                        pf_cfg_o.colorbase <= reg_data_i[15:8];
                        pf_cfg_o.blank     <= reg_data_i[7];
                    end
                    REG_PF_DISP_ADDR: pf_cfg_o.start_addr    <= reg_data_i;
                    REG_PF_LINE_LEN:  pf_cfg_o.line_len      <= reg_data_i;
                    default: ;                                  // scanline and holes ignore writes
                endcase
            end
        end
    end

    always_comb begin
        rd_data = '0;                                           // holes read zero
        case (reg_num_i)
            REG_VID_CTRL:     rd_data = {8'h00, vid_cfg_o.border_color};
            REG_SCANLINE:     rd_data = word_t'(raster_i.v_count);
            REG_VID_LEFT:     rd_data = word_t'(vid_cfg_o.vid_left);
            REG_VID_RIGHT:    rd_data = word_t'(vid_cfg_o.vid_right);
            REG_PF_GFX_CTRL:  rd_data = {pf_cfg_o.colorbase, pf_cfg_o.blank, 7'b0};
            REG_PF_DISP_ADDR: rd_data = pf_cfg_o.start_addr;
            REG_PF_LINE_LEN:  rd_data = pf_cfg_o.line_len;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= rd_data;                                  // no side effect on read
    end

    // the interrupt is a single-clock pulse
    assert property (@(posedge clk) disable iff (reset_i) video_intr_o |=> !video_intr_o)
        else $error("video_intr_o high for more than one clock");

endmodule

`default_nettype wire

/* rtl/video_timing.sv */
/*
 * Raster timing generator. Free-running pixel counters give the raster status
 * bundle; sync and data-enable are registered from the same counts.
 */
`default_nettype none
`timescale 1ns/100ps

module video_timing (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    output video_timing_pkg::raster_t raster_o,
    output logic                      hsync_o,
    output logic                      vsync_o,
    output logic                      dv_de_o
);
    import video_timing_pkg::*;

    localparam int H_SYNC_START = VISIBLE_WIDTH + H_FRONT_PORCH;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC_PULSE;
    localparam int V_SYNC_START = VISIBLE_HEIGHT + V_FRONT_PORCH;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC_PULSE;

    hres_t h_count;
    vres_t v_count;
    logic  h_visible;
    logic  v_visible;
    logic  end_of_line;
    logic  in_hsync;
    logic  in_vsync;

    always_comb begin
        h_visible   = h_count < hres_t'(VISIBLE_WIDTH);
        v_visible   = v_count < vres_t'(VISIBLE_HEIGHT);
        end_of_line = h_count == hres_t'(TOTAL_WIDTH - 1);
        in_hsync    = (h_count >= hres_t'(H_SYNC_START)) && (h_count < hres_t'(H_SYNC_END));
        in_vsync    = (v_count >= vres_t'(V_SYNC_START)) && (v_count < vres_t'(V_SYNC_END));

        raster_o.h_count        = h_count;
        raster_o.v_count        = v_count;
        raster_o.h_visible      = h_visible;
        raster_o.v_visible      = v_visible;
        raster_o.end_of_line    = end_of_line;
        raster_o.end_of_frame   = end_of_line && (v_count == vres_t'(TOTAL_HEIGHT - 1));
        raster_o.end_of_visible = end_of_line && (v_count == vres_t'(VISIBLE_HEIGHT - 1));
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count <= '0;
            v_count <= '0;
            hsync_o <= ~SYNC_POLARITY;
            vsync_o <= ~SYNC_POLARITY;
            dv_de_o <= 1'b0;
        end else begin
            h_count <= end_of_line ? '0 : h_count + 1'b1;
            if (end_of_line) begin
                v_count <= (v_count == vres_t'(TOTAL_HEIGHT - 1)) ? '0 : v_count + 1'b1;
            end
            hsync_o <= in_hsync ? SYNC_POLARITY : ~SYNC_POLARITY;    // lags counts by one
            vsync_o <= in_vsync ? SYNC_POLARITY : ~SYNC_POLARITY;
            dv_de_o <= h_visible && v_visible;
        end
    end

    // counters must wrap on the last clock of a line and of a frame
    assert property (@(posedge clk) disable iff (reset_i)
        (h_count < hres_t'(TOTAL_WIDTH)) && (v_count < vres_t'(TOTAL_HEIGHT)))
        else $error("raster counter ran past its total");

endmodule

`default_nettype wire

/* rtl/video_timing_pkg.sv */
/*
 * Raster geometry for the 640x480 mode and the raster status bundle that the
 * timing generator hands to the register block and the playfield.
 */
`default_nettype none

package video_timing_pkg;

    localparam int VISIBLE_WIDTH  = 640;
    localparam int VISIBLE_HEIGHT = 480;

    localparam int H_FRONT_PORCH  = 16;
    localparam int H_SYNC_PULSE   = 96;
    localparam int H_BACK_PORCH   = 48;

    localparam int V_FRONT_PORCH  = 10;
    localparam int V_SYNC_PULSE   = 2;
    localparam int V_BACK_PORCH   = 33;

    localparam int TOTAL_WIDTH  = VISIBLE_WIDTH + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
    localparam int TOTAL_HEIGHT = VISIBLE_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

    localparam logic SYNC_POLARITY = 1'b0;     // both syncs active low

    typedef logic [9:0] hres_t;
    typedef logic [9:0] vres_t;

    typedef struct packed {
        hres_t h_count;
        vres_t v_count;
        logic  h_visible;
        logic  v_visible;
        logic  end_of_line;                     // last clock of every line
        logic  end_of_frame;                    // last clock of line 524
        logic  end_of_visible;                  // last clock of line 479
    } raster_t;

endpackage

`default_nettype wire

/* sim.f */
+incdir+sim
rtl/video_timing_pkg.sv
rtl/video_cfg_pkg.sv
rtl/video_timing.sv
rtl/video_regs.sv
rtl/bitmap_playfield.sv
rtl/video_gen.sv
sim/tb_video_gen.sv

/* sim/tb_video_checks.svh */
/*
 * Compare tasks, the vram fill pattern and the reference pixel model.
 * Included inside the testbench module, after its shared variables.
 */
`ifndef TB_VIDEO_CHECKS_SVH
`define TB_VIDEO_CHECKS_SVH
`default_nettype none

task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_color(input color_t got, input color_t exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Fail at %0t ns: %s has index %h, expected %h", $time, what, got, exp);
    end
endtask

// high byte folds both address bytes, low byte is its inverse
function automatic word_t mem_word(input addr_t addr);
    color_t hi;
    hi = addr[7:0] ^ addr[15:8];
    return {hi, ~hi};
endfunction

// expected index for column x of row y under the current configuration
function automatic color_t expected_pixel(input int x, input int y);
    addr_t addr;
    word_t w;
    if (exp_pf.blank || x < int'(exp_vid.vid_left) || x >= int'(exp_vid.vid_right)) begin
        return exp_vid.border_color;                // border is never XORed
    end
    addr = addr_t'(int'(exp_pf.start_addr) + y * int'(exp_pf.line_len) + x / 2);
    w    = mem_word(addr);
    return ((x % 2 == 0) ? w[15:8] : w[7:0]) ^ exp_pf.colorbase;
endfunction

`default_nettype wire
`endif

/* sim/tb_video_gen.sv */
/*
 * Directed testbench for the video generator: register port, raster timing,
 * bitmap pixels against a reference model, border window and interrupt.
 */
`default_nettype none
`timescale 1ns/100ps

module tb_video_gen;
    import video_timing_pkg::*;
    import video_cfg_pkg::*;

    localparam int FRAME_CLKS  = TOTAL_WIDTH * TOTAL_HEIGHT;
    localparam int TEST_FRAMES = 7;     // raster 2, pixels 2, border 2, irq 1
    localparam int CYCLE_LIMIT = (TEST_FRAMES + 1) * FRAME_CLKS;

    logic clk = 1'b0;
    logic reset_i;
    logic reg_wr_i;
    reg_num_t reg_num_i;
    word_t reg_data_i;
    word_t reg_data_o;
    logic video_intr_o;
    logic vram_sel_o;
    addr_t vram_addr_o;
    word_t vram_data_i = '0;
    color_t color_index_o;
    logic hsync_o, vsync_o, dv_de_o, h_blank_o, v_blank_o;

    vid_cfg_t exp_vid;                  // configuration the model assumes
    pf_cfg_t  exp_pf;
    int checks = 0;
    int errors = 0;
    int cycles = 0;
    logic req_pending = 1'b0;
    addr_t req_addr = '0;
    reg_num_t exp_unused[5] = '{6'd1, 6'd5, 6'd17, 6'd20, 6'd63};

    video_gen dut (.*);

    always #10 clk = ~clk;

    // vram answers one clock after each select
    always @(negedge clk) begin
        if (req_pending) vram_data_i <= mem_word(req_addr);
        req_pending <= vram_sel_o;
        req_addr    <= vram_addr_o;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic write_reg(input reg_num_t num, input word_t data);
        @(negedge clk);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(negedge clk);
        reg_wr_i   = 1'b0;
    endtask

    task automatic read_reg(input reg_num_t num, output word_t data);
        @(negedge clk);
        reg_num_i = num;
        @(negedge clk);
        data = reg_data_o;              // registered one clock after the number
    endtask

    task automatic set_config(input vid_cfg_t v, input pf_cfg_t p);
        write_reg(REG_VID_CTRL, {8'h00, v.border_color});
        write_reg(REG_VID_LEFT, word_t'(v.vid_left));
        write_reg(REG_VID_RIGHT, word_t'(v.vid_right));
        write_reg(REG_PF_GFX_CTRL, {p.colorbase, p.blank, 7'b0});
        write_reg(REG_PF_DISP_ADDR, p.start_addr);
        write_reg(REG_PF_LINE_LEN, p.line_len);
        exp_vid = v;
        exp_pf  = p;
    endtask

    // returns on the first clock after a vsync pulse
    task automatic sync_to_new_frame;
        @(negedge clk);
        while (vsync_o) @(negedge clk);
        while (!vsync_o) @(negedge clk);
    endtask

    task automatic scan_frame(input bit all_rows);
        int row;
        int col;
        bit prev_de;
        row = 0;
        col = 0;
        prev_de = 1'b0;
        while (row < VISIBLE_HEIGHT) begin
            @(negedge clk);
            if (dv_de_o) begin
                if (all_rows || row < 2 || row == VISIBLE_HEIGHT - 1) begin
                    check_color(color_index_o, expected_pixel(col, row),
                                $sformatf("pixel %0d,%0d", col, row));
                end
                col++;
            end else if (prev_de) begin
                row++;
                col = 0;
            end
            prev_de = dv_de_o;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - errs_before);
    endtask

    task automatic test_reset_values;
        int e0;
        word_t d;
        e0 = errors;
        read_reg(REG_VID_CTRL, d);
        check_word(d, 16'h0008, "VID_CTRL after reset");
        read_reg(REG_VID_LEFT, d);
        check_word(d, 16'd0, "VID_LEFT after reset");
        read_reg(REG_VID_RIGHT, d);
        check_word(d, 16'd640, "VID_RIGHT after reset");
        read_reg(REG_PF_LINE_LEN, d);
        check_word(d, 16'd320, "PF_LINE_LEN after reset");
        read_reg(REG_PF_GFX_CTRL, d);
        check_word(d, 16'h0080, "PF_GFX_CTRL after reset");
        foreach (exp_unused[i]) begin
            read_reg(exp_unused[i], d);
            check_word(d, 16'h0000, $sformatf("unused register %0d", exp_unused[i]));
        end
        finish_test("reset_values", e0);
    endtask

    task automatic test_register_writes;
        int e0;
        word_t d;
        word_t got;
        reg_num_t nums[6] = '{REG_VID_CTRL, REG_VID_LEFT, REG_VID_RIGHT, REG_PF_GFX_CTRL,
                              REG_PF_DISP_ADDR, REG_PF_LINE_LEN};
        word_t masks[6] = '{16'h00ff, 16'h03ff, 16'h03ff, 16'hff80, 16'hffff, 16'hffff};
        e0 = errors;
        foreach (nums[i]) begin
            d = word_t'($urandom);
            write_reg(nums[i], d);
            read_reg(nums[i], got);
            check_word(got, d & masks[i], $sformatf("register %0d after write", nums[i]));
        end
        write_reg(REG_SCANLINE, word_t'($urandom) | 16'hff00);    // out of raster range
        read_reg(REG_SCANLINE, got);
        checks++;
        if (int'(got) >= TOTAL_HEIGHT) begin
            errors++;
            $display("Fail at %0t ns: scanline reads %0d after a host write", $time, got);
        end
        finish_test("register_writes", e0);
    endtask

    task automatic test_raster;
        int e0, hsyncs, vsyncs, de_lines, de_clks, min_clks, max_clks, max_line;
        int hvis_clks, vvis_clks, de_blanked;
        bit prev_h, prev_v, prev_de;
        e0 = errors;
        {hsyncs, vsyncs, de_lines, de_clks, max_clks, max_line} = '0;
        {hvis_clks, vvis_clks, de_blanked} = '0;
        min_clks = 1 << 30;
        reg_num_i = REG_SCANLINE;
        sync_to_new_frame();
        {prev_h, prev_v, prev_de} = {hsync_o, vsync_o, 1'b0};
        repeat (FRAME_CLKS) begin
            @(negedge clk);
            if (prev_h && !hsync_o) hsyncs++;
            if (prev_v && !vsync_o) vsyncs++;
            if (dv_de_o) begin
                de_clks++;
            end else if (prev_de) begin
                de_lines++;
                if (de_clks < min_clks) min_clks = de_clks;
                if (de_clks > max_clks) max_clks = de_clks;
                de_clks = 0;
            end
            if (!h_blank_o) hvis_clks++;
            if (!v_blank_o) vvis_clks++;
            if (dv_de_o && (h_blank_o || v_blank_o)) de_blanked++;
            if (int'(reg_data_o) > max_line) max_line = int'(reg_data_o);
            {prev_h, prev_v, prev_de} = {hsync_o, vsync_o, dv_de_o};
        end
        check_word(word_t'(hsyncs), 16'd525, "hsync pulses per frame");
        check_word(word_t'(vsyncs), 16'd1, "vsync pulses per frame");
        check_word(word_t'(de_lines), 16'd480, "lines with dv_de");
        check_word(word_t'(min_clks), 16'd640, "shortest dv_de line");
        check_word(word_t'(max_clks), 16'd640, "longest dv_de line");
        check_word(word_t'(hvis_clks / TOTAL_HEIGHT), 16'd640, "h_blank low clocks per line");
        check_word(word_t'(hvis_clks % TOTAL_HEIGHT), 16'd0, "h_blank low clocks left over");
        check_word(word_t'(vvis_clks / TOTAL_WIDTH), 16'd480, "lines with v_blank low");
        check_word(word_t'(vvis_clks % TOTAL_WIDTH), 16'd0, "v_blank low clocks left over");
        check_word(word_t'(de_blanked), 16'd0, "dv_de clocks flagged as blank");
        check_word(word_t'(max_line), 16'd524, "highest scanline read");
        finish_test("raster", e0);
    endtask

    task automatic test_pixels;
        int e0;
        vid_cfg_t v;
        pf_cfg_t p;
        e0 = errors;
        v.border_color = BORDER_RESET;
        v.vid_left     = '0;
        v.vid_right    = hpos_t'(VISIBLE_WIDTH);
        p.blank        = 1'b0;
        p.colorbase    = color_t'($urandom);
        p.start_addr   = addr_t'($urandom);
        p.line_len     = 16'd320;
        set_config(v, p);
        sync_to_new_frame();
        scan_frame(1'b0);
        finish_test("pixels", e0);
    endtask

    task automatic test_border;
        int e0;
        vid_cfg_t v;
        pf_cfg_t p;
        e0 = errors;
        v = exp_vid;
        p = exp_pf;
        v.border_color = color_t'($urandom);
        v.vid_left     = hpos_t'(100);
        v.vid_right    = hpos_t'(300);
        set_config(v, p);
        sync_to_new_frame();
        scan_frame(1'b0);
        p.blank = 1'b1;                 // whole visible area turns to border
        set_config(v, p);
        sync_to_new_frame();
        scan_frame(1'b1);
        finish_test("border", e0);
    endtask

    task automatic test_interrupt;
        int e0, pulses, high_clks, rows, row_at_intr;
        bit prev_i, prev_v, prev_de, seen_v, done;
        e0 = errors;
        {pulses, high_clks, rows, row_at_intr} = '0;
        {seen_v, done} = '0;
        sync_to_new_frame();
        {prev_i, prev_v, prev_de} = {video_intr_o, vsync_o, dv_de_o};
        while (!done) begin
            @(negedge clk);
            if (prev_de && !dv_de_o) rows++;
            if (video_intr_o) high_clks++;
            if (video_intr_o && !prev_i) begin
                pulses++;
                row_at_intr = rows;
            end
            if (prev_v && !vsync_o) seen_v = 1'b1;
            done = seen_v && !prev_v && vsync_o;
            {prev_i, prev_v, prev_de} = {video_intr_o, vsync_o, dv_de_o};
        end
        check_word(word_t'(pulses), 16'd1, "interrupt pulses per frame");
        check_word(word_t'(high_clks), 16'd1, "interrupt high clocks");
        check_word(word_t'(row_at_intr), 16'd480, "rows finished at interrupt");
        finish_test("interrupt", e0);
    endtask

    initial begin
        void'($urandom(32'h3efa));
        reset_i    = 1'b1;
        reg_wr_i   = 1'b0;
        reg_num_i  = '0;
        reg_data_i = '0;
        repeat (8) @(negedge clk);
        reset_i = 1'b0;
        test_reset_values();
        test_register_writes();
        test_raster();
        test_pixels();
        test_border();
        test_interrupt();
        $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    `include "tb_video_checks.svh"

endmodule

`default_nettype wire
